// ==== logic/lc4_pkg.sv ====
`default_nettype none

package lc4_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS  = 8;

    localparam logic [WORD_W-1:0] RESET_PC = 16'h8200;

    // major opcodes in insn[15:12]
    localparam logic [3:0] OPC_BR    = 4'b0000;
    localparam logic [3:0] OPC_ARITH = 4'b0001;
    localparam logic [3:0] OPC_LOGIC = 4'b0101;
    localparam logic [3:0] OPC_LDR   = 4'b0110;
    localparam logic [3:0] OPC_STR   = 4'b0111;
    localparam logic [3:0] OPC_CONST = 4'b1001;

    // register-register function codes in insn[5:3]
    localparam logic [2:0] FN_ADD = 3'b000;
    localparam logic [2:0] FN_SUB = 3'b010;
    localparam logic [2:0] FN_AND = 3'b000;
    localparam logic [2:0] FN_OR  = 3'b010;
    localparam logic [2:0] FN_XOR = 3'b011;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [WORD_W-1:0]    insn_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // n in bit 2, z in bit 1, p in bit 0
    typedef logic [2:0] nzp_t;

    // retire stall code seen on the trace port
    typedef enum logic [1:0] {
        STALL_NONE   = 2'd0,
        STALL_PIPE   = 2'd1,
        STALL_BRANCH = 2'd2,
        STALL_LOAD   = 2'd3
    } stall_e;

    typedef struct packed {
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
    } ctrl_t;

    typedef struct packed {
        word_t  pc;
        insn_t  insn;
        ctrl_t  ctrl;
        stall_e stall;
    } stage_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        word_t    pc;
        insn_t    insn;
        stall_e   stall;
        logic     rd_we;
        reg_idx_t rd;
        word_t    rd_data;
        logic     nzp_we;
        nzp_t     nzp;
        logic     dmem_we;
        word_t    dmem_addr;
        word_t    dmem_data;
    } wb_trace_t;

    // sign class of a result as loaded into the NZP register
    function automatic nzp_t nzp_of(word_t value);
        if (value[WORD_W-1]) begin
            return 3'b100;
        end else if (value == '0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    // empty slot with no enables that carries the reason it exists
    function automatic stage_t bubble(stall_e code);
        stage_t s;
        s       = '0;
        s.stall = code;
        return s;
    endfunction

endpackage

`default_nettype wire

// ==== logic/lc4_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc4_decoder import lc4_pkg::*; (
    input  wire insn_t i_insn,
    output ctrl_t      o_ctrl
);

    logic [3:0] opcode;
    logic [2:0] fn;
    logic       alu_rr;
    logic       alu_imm;

    assign opcode = i_insn[15:12];
    assign fn     = i_insn[5:3];

    // which register-register and immediate forms are kept
    always_comb begin
        alu_rr  = 1'b0;
        alu_imm = 1'b0;
        case (opcode)
            OPC_ARITH: begin
                alu_imm = i_insn[5];
                alu_rr  = !i_insn[5] && (fn == FN_ADD || fn == FN_SUB);
            end
            OPC_LOGIC: begin
                alu_rr = !i_insn[5] && (fn == FN_AND || fn == FN_OR || fn == FN_XOR);
            end
            default: begin
                alu_rr  = 1'b0;
                alu_imm = 1'b0;
            end
        endcase
    end

    always_comb begin
        // anything not matched below falls out as a NOP
        o_ctrl = '0;
        if (alu_rr || alu_imm) begin
            o_ctrl.rd     = i_insn[11:9];
            o_ctrl.rs     = i_insn[8:6];
            o_ctrl.rt     = i_insn[2:0];
            o_ctrl.rs_re  = 1'b1;
            o_ctrl.rt_re  = alu_rr;
            o_ctrl.rd_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
        end else begin
            case (opcode)
                OPC_BR: begin
                    // nzp mask of 000 is the NOP encoding
                    o_ctrl.is_branch = (i_insn[11:9] != 3'b000);
                end
                OPC_LDR: begin
                    o_ctrl.rd      = i_insn[11:9];
                    o_ctrl.rs      = i_insn[8:6];
                    o_ctrl.rs_re   = 1'b1;
                    o_ctrl.rd_we   = 1'b1;
                    o_ctrl.nzp_we  = 1'b1;
                    o_ctrl.is_load = 1'b1;
                end
                OPC_STR: begin
                    // store data register sits in the rd field
                    o_ctrl.rt       = i_insn[11:9];
                    o_ctrl.rs       = i_insn[8:6];
                    o_ctrl.rs_re    = 1'b1;
                    o_ctrl.rt_re    = 1'b1;
                    o_ctrl.is_store = 1'b1;
                end
                OPC_CONST: begin
                    o_ctrl.rd     = i_insn[11:9];
                    o_ctrl.rd_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
                default: begin
                    o_ctrl = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/lc4_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc4_alu import lc4_pkg::*; (
    input  wire insn_t i_insn,
    input  wire word_t i_pc,
    input  wire word_t i_rs_data,
    input  wire word_t i_rt_data,
    output word_t      o_result
);

    word_t imm5;
    word_t imm6;
    word_t imm9;

    // sign-extended immediates
    assign imm5 = {{(WORD_W-5){i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{(WORD_W-6){i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{(WORD_W-9){i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        o_result = '0;
        case (i_insn[15:12])
            OPC_BR: begin
                // branch target that matters only when taken
                o_result = i_pc + word_t'(1) + imm9;
            end
            OPC_ARITH: begin
                if (i_insn[5]) begin
                    o_result = i_rs_data + imm5;
                end else begin
                    case (i_insn[5:3])
                        FN_ADD:  o_result = i_rs_data + i_rt_data;
                        FN_SUB:  o_result = i_rs_data - i_rt_data;
                        default: o_result = '0;
                    endcase
                end
            end
            OPC_LOGIC: begin
                case (i_insn[5:3])
                    FN_AND:  o_result = i_rs_data & i_rt_data;
                    FN_OR:   o_result = i_rs_data | i_rt_data;
                    FN_XOR:  o_result = i_rs_data ^ i_rt_data;
                    default: o_result = '0;
                endcase
            end
            OPC_LDR, OPC_STR: begin
                // effective address
                o_result = i_rs_data + imm6;
            end
            OPC_CONST: begin
                o_result = imm9;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/lc4_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc4_regfile import lc4_pkg::*; (
    input  wire logic     gwe,
    input  wire logic     i_rst_n,
    input  wire reg_idx_t i_rs,
    input  wire reg_idx_t i_rt,
    output word_t         o_rs_data,
    output word_t         o_rt_data,
    input  wire reg_idx_t i_rd,
    input  wire logic     i_rd_we,
    input  wire word_t    i_wdata
);

    word_t regs [NUM_REGS];

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // writeback value is visible to decode in the same cycle
    assign o_rs_data = (i_rd_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_rd_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

// ==== logic/lc4_fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc4_fetch_unit import lc4_pkg::*; (
    input  wire logic  gwe,
    input  wire logic  i_rst_n,
    input  wire logic  i_stall,
    input  wire logic  i_redirect,
    input  wire word_t i_target,
    output word_t      o_pc
);

    word_t pc_q;
    word_t pc_next;

    // a taken branch wins over a load-use hold, since the held
    // instruction is being flushed anyway
    always_comb begin
        if (i_redirect) begin
            pc_next = i_target;
        end else if (i_stall) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_q + word_t'(1);
        end
    end

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign o_pc = pc_q;

endmodule

`default_nettype wire

// ==== logic/lc4_hazard_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc4_hazard_unit import lc4_pkg::*; (
    input  wire ctrl_t i_d_ctrl,
    input  wire ctrl_t i_x_ctrl,
    input  wire ctrl_t i_m_ctrl,
    input  wire ctrl_t i_w_ctrl,
    input  wire word_t i_x_rs_reg,
    input  wire word_t i_x_rt_reg,
    input  wire word_t i_m_result,
    input  wire word_t i_m_store,
    input  wire word_t i_w_result,
    output logic       o_stall,
    output word_t      o_alu_a,
    output word_t      o_alu_b,
    output word_t      o_store_data
);

    logic load_use;
    logic load_branch;
    logic a_from_m;
    logic a_from_w;
    logic b_from_m;
    logic b_from_w;
    logic st_from_w;

    // load in X feeding a register source in D
    assign load_use = i_x_ctrl.is_load &&
                      ((i_d_ctrl.rs_re && i_d_ctrl.rs == i_x_ctrl.rd) ||
                       (i_d_ctrl.rt_re && i_d_ctrl.rt == i_x_ctrl.rd));

    // the load sets NZP only at the end of M, so a branch right
    // behind it must wait one cycle as well
    assign load_branch = i_x_ctrl.is_load && i_d_ctrl.is_branch;

    assign o_stall = load_use || load_branch;

    // MX has priority over WX
    // the load-use stall keeps a load in M away from a consumer in X
    assign a_from_m = i_m_ctrl.rd_we && i_m_ctrl.rd == i_x_ctrl.rs;
    assign a_from_w = i_w_ctrl.rd_we && i_w_ctrl.rd == i_x_ctrl.rs;
    assign b_from_m = i_m_ctrl.rd_we && i_m_ctrl.rd == i_x_ctrl.rt;
    assign b_from_w = i_w_ctrl.rd_we && i_w_ctrl.rd == i_x_ctrl.rt;

    assign o_alu_a = a_from_m ? i_m_result :
                     a_from_w ? i_w_result :
                     i_x_rs_reg;

    assign o_alu_b = b_from_m ? i_m_result :
                     b_from_w ? i_w_result :
                     i_x_rt_reg;

    // WM bypass covers a load or ALU op just ahead of the store
    assign st_from_w = i_m_ctrl.is_store && i_w_ctrl.rd_we &&
                       i_w_ctrl.rd == i_m_ctrl.rt;

    assign o_store_data = st_from_w ? i_w_result : i_m_store;

endmodule

`default_nettype wire

// ==== logic/lc4_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc4_pipeline import lc4_pkg::*; (
    input  wire logic  gwe,
    input  wire logic  i_rst_n,
    output word_t      o_imem_addr,
    input  wire insn_t i_imem_insn,
    output dmem_req_t  o_dmem,
    input  wire word_t i_dmem_rdata,
    output wb_trace_t  o_wb
);

    stage_t d_q;
    stage_t x_q;
    stage_t m_q;
    stage_t w_q;
    stage_t d_next;
    stage_t x_next;
    stage_t x_from_d;
    ctrl_t  d_ctrl;
    nzp_t   nzp_q;

    word_t  f_pc;
    word_t  rf_rs_data;
    word_t  rf_rt_data;
    word_t  x_rs_q;
    word_t  x_rt_q;
    word_t  alu_a;
    word_t  alu_b;
    word_t  alu_result;
    word_t  m_result_q;
    word_t  m_store_q;
    word_t  store_data;
    word_t  w_alu_q;
    word_t  w_load_q;
    word_t  w_store_q;
    word_t  w_result;
    logic   stall;
    logic   br_taken;

    lc4_fetch_unit fetch_inst (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .i_stall    (stall),
        .i_redirect (br_taken),
        .i_target   (alu_result),
        .o_pc       (f_pc)
    );

    assign o_imem_addr = f_pc;

    lc4_decoder decoder_inst (
        .i_insn (d_q.insn),
        .o_ctrl (d_ctrl)
    );

    lc4_regfile regfile_inst (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs      (d_ctrl.rs),
        .i_rt      (d_ctrl.rt),
        .o_rs_data (rf_rs_data),
        .o_rt_data (rf_rt_data),
        .i_rd      (w_q.ctrl.rd),
        .i_rd_we   (w_q.ctrl.rd_we),
        .i_wdata   (w_result)
    );

    lc4_hazard_unit hazard_inst (
        .i_d_ctrl     (d_ctrl),
        .i_x_ctrl     (x_q.ctrl),
        .i_m_ctrl     (m_q.ctrl),
        .i_w_ctrl     (w_q.ctrl),
        .i_x_rs_reg   (x_rs_q),
        .i_x_rt_reg   (x_rt_q),
        .i_m_result   (m_result_q),
        .i_m_store    (m_store_q),
        .i_w_result   (w_result),
        .o_stall      (stall),
        .o_alu_a      (alu_a),
        .o_alu_b      (alu_b),
        .o_store_data (store_data)
    );

    lc4_alu alu_inst (
        .i_insn    (x_q.insn),
        .i_pc      (x_q.pc),
        .i_rs_data (alu_a),
        .i_rt_data (alu_b),
        .o_result  (alu_result)
    );

    // branch resolves in X against the committed NZP
    assign br_taken = x_q.ctrl.is_branch && ((nzp_q & x_q.insn[11:9]) != 3'b000);

    always_comb begin
        x_from_d      = d_q;
        x_from_d.ctrl = d_ctrl;
        d_next        = d_q;
        x_next        = x_from_d;
        if (br_taken) begin
            d_next = bubble(STALL_BRANCH);
            x_next = bubble(STALL_BRANCH);
        end else if (stall) begin
            x_next = bubble(STALL_LOAD);
        end else begin
            d_next.pc    = f_pc;
            d_next.insn  = i_imem_insn;
            d_next.ctrl  = '0;
            d_next.stall = STALL_NONE;
        end
    end

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            d_q   <= bubble(STALL_PIPE);
            x_q   <= bubble(STALL_PIPE);
            m_q   <= bubble(STALL_PIPE);
            w_q   <= bubble(STALL_PIPE);
            nzp_q <= '0;
        end else begin
            d_q <= d_next;
            x_q <= x_next;
            m_q <= x_q;
            w_q <= m_q;
            // the younger ALU result in X overrides a load finishing in M
            if (x_q.ctrl.nzp_we && !x_q.ctrl.is_load) begin
                nzp_q <= nzp_of(alu_result);
            end else if (m_q.ctrl.is_load) begin
                nzp_q <= nzp_of(i_dmem_rdata);
            end
        end
    end

    always_ff @(posedge gwe) begin
        x_rs_q     <= rf_rs_data;
        x_rt_q     <= rf_rt_data;
        m_result_q <= alu_result;
        m_store_q  <= alu_b;
        w_alu_q    <= m_result_q;
        w_load_q   <= i_dmem_rdata;
        w_store_q  <= store_data;
    end

    always_comb begin
        o_dmem.we    = m_q.ctrl.is_store;
        o_dmem.addr  = (m_q.ctrl.is_load || m_q.ctrl.is_store) ? m_result_q : '0;
        o_dmem.wdata = m_q.ctrl.is_store ? store_data : '0;
    end

    assign w_result = w_q.ctrl.is_load ? w_load_q : w_alu_q;

    // retire record
    always_comb begin
        o_wb.pc        = w_q.pc;
        o_wb.insn      = w_q.insn;
        o_wb.stall     = w_q.stall;
        o_wb.rd_we     = w_q.ctrl.rd_we;
        o_wb.rd        = w_q.ctrl.rd;
        o_wb.rd_data   = w_result;
        o_wb.nzp_we    = w_q.ctrl.nzp_we;
        o_wb.nzp       = w_q.ctrl.nzp_we ? nzp_of(w_result) : '0;
        o_wb.dmem_we   = w_q.ctrl.is_store;
        o_wb.dmem_addr = (w_q.ctrl.is_load || w_q.ctrl.is_store) ? w_alu_q : '0;
        o_wb.dmem_data = w_q.ctrl.is_load  ? w_load_q :
                         w_q.ctrl.is_store ? w_store_q : '0;
    end

endmodule

`default_nettype wire

// ==== dv/lc4_pipeline_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc4_pipeline_assertions import lc4_pkg::*; (
    input wire logic      gwe,
    input wire logic      i_rst_n,
    input wire wb_trace_t i_wb,
    input wire dmem_req_t i_dmem,
    input wire word_t     i_m_pc
);

    localparam int PROG_LEN  = 31;
    localparam int TABLE_LEN = 32;

    int unsigned error_count = 0;

    // expected retire record per program slot
    logic       exp_rd_we  [TABLE_LEN];
    reg_idx_t   exp_rd     [TABLE_LEN];
    word_t      exp_data   [TABLE_LEN];
    logic       exp_st     [TABLE_LEN];
    word_t      exp_addr   [TABLE_LEN];
    word_t      exp_wdata  [TABLE_LEN];
    logic       exp_retire [TABLE_LEN];
    // next slot on the trace and the bubbles before it
    logic [4:0] exp_next   [TABLE_LEN];
    logic [2:0] exp_lgap   [TABLE_LEN];
    logic [2:0] exp_bgap   [TABLE_LEN];

    word_t      wb_off;
    word_t      m_off;
    logic [4:0] wb_idx;
    logic [4:0] m_idx;
    logic       wb_in_prog;
    logic       m_in_prog;
    logic       retire;
    logic       started;
    logic       have_prev;
    logic [4:0] prev_idx;
    logic [2:0] load_gap;
    logic [2:0] br_gap;

    function automatic nzp_t sign_class(input word_t v);
        if (v[15]) begin
            return 3'b100;
        end
        if (v == 16'h0000) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    task automatic set_wb(input int idx, input reg_idx_t rd, input word_t data);
        exp_rd_we[idx] = 1'b1;
        exp_rd[idx]    = rd;
        exp_data[idx]  = data;
    endtask

    task automatic set_store(input int idx, input word_t addr, input word_t data);
        exp_st[idx]    = 1'b1;
        exp_addr[idx]  = addr;
        exp_wdata[idx] = data;
    endtask

    task automatic set_flow(input int idx, input int nxt, input int lgap, input int bgap);
        exp_next[idx] = 5'(nxt);
        exp_lgap[idx] = 3'(lgap);
        exp_bgap[idx] = 3'(bgap);
    endtask

    initial begin
        for (int i = 0; i < TABLE_LEN; i++) begin
            exp_rd_we[i]  = 1'b0;
            exp_rd[i]     = '0;
            exp_data[i]   = '0;
            exp_st[i]     = 1'b0;
            exp_addr[i]   = '0;
            exp_wdata[i]  = '0;
            exp_retire[i] = (i < PROG_LEN);
            set_flow(i, i + 1, 0, 0);
        end
        // ALU chain with MX and WX operands
        set_wb(0, 3'd1, 16'h0005);
        set_wb(1, 3'd2, 16'hfffd);
        set_wb(2, 3'd3, 16'h0002);
        set_wb(3, 3'd4, 16'hffff);
        set_wb(4, 3'd5, 16'h0005);
        set_wb(5, 3'd6, 16'h0007);
        set_wb(6, 3'd7, 16'h0000);
        set_wb(7, 3'd7, 16'hffff);
        set_wb(8, 3'd0, 16'h0010);
        set_wb(9, 3'd5, 16'h0008);
        // stores, loads and load-use pairs
        set_store(10, 16'h0012, 16'h0008);
        set_wb(11, 3'd2, 16'h0008);
        set_flow(11, 12, 1, 0);
        set_wb(12, 3'd3, 16'h000d);
        set_store(13, 16'h0013, 16'h000d);
        set_wb(14, 3'd4, 16'h000d);
        set_flow(14, 15, 1, 0);
        set_store(15, 16'h0014, 16'h000d);
        set_wb(16, 3'd5, 16'h000d);
        set_flow(16, 17, 1, 0);
        set_wb(17, 3'd6, 16'h0000);
        // BRn not taken, BRz taken, BRnzp taken
        set_flow(19, 22, 0, 2);
        exp_retire[20] = 1'b0;
        exp_retire[21] = 1'b0;
        set_wb(22, 3'd1, 16'h0006);
        set_flow(23, 25, 0, 2);
        exp_retire[24] = 1'b0;
        set_wb(25, 3'd2, 16'h000b);
        set_wb(26, 3'd3, 16'h000c);
        set_store(28, 16'h0015, 16'h000c);
        set_wb(29, 3'd4, 16'h000c);
        set_flow(29, 30, 1, 0);
        set_wb(30, 3'd6, 16'h0018);
    end

    assign wb_off     = i_wb.pc - RESET_PC;
    assign m_off      = i_m_pc - RESET_PC;
    assign wb_idx     = wb_off[4:0];
    assign m_idx      = m_off[4:0];
    assign wb_in_prog = (wb_off < 16'(PROG_LEN));
    assign m_in_prog  = (m_off < 16'(PROG_LEN));
    assign retire     = (i_wb.stall == STALL_NONE);

    // bubbles seen since the last real retire
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            started   <= 1'b0;
            have_prev <= 1'b0;
            prev_idx  <= '0;
            load_gap  <= '0;
            br_gap    <= '0;
        end else if (retire) begin
            started   <= 1'b1;
            have_prev <= 1'b1;
            prev_idx  <= wb_idx;
            load_gap  <= '0;
            br_gap    <= '0;
        end else begin
            if (i_wb.stall == STALL_LOAD) begin
                load_gap <= load_gap + 3'd1;
            end
            if (i_wb.stall == STALL_BRANCH) begin
                br_gap <= br_gap + 3'd1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge gwe)
        !started && !retire |-> !i_wb.rd_we && !i_wb.nzp_we && !i_dmem.we)
    else begin
        $error("ERROR o_wb.rd_we %h o_wb.nzp_we %h o_dmem.we %h before the first retire",
               $sampled(i_wb.rd_we), $sampled(i_wb.nzp_we), $sampled(i_dmem.we));
        error_count++;
    end

    a_retire_pc: assert property (@(posedge gwe) disable iff (!i_rst_n)
        retire |-> wb_in_prog && exp_retire[wb_idx] &&
                   (have_prev || i_wb.pc == RESET_PC))
    else begin
        $error("ERROR o_wb.pc %h retired but should not", $sampled(i_wb.pc));
        error_count++;
    end

    a_retire_order: assert property (@(posedge gwe) disable iff (!i_rst_n)
        retire && have_prev |-> wb_idx == exp_next[prev_idx] &&
                                load_gap == exp_lgap[prev_idx] &&
                                br_gap == exp_bgap[prev_idx])
    else begin
        $error("ERROR o_wb.pc got %h expected %h, load bubbles %h, branch bubbles %h",
               $sampled(i_wb.pc), RESET_PC + 16'($sampled(exp_next[prev_idx])),
               $sampled(load_gap), $sampled(br_gap));
        error_count++;
    end

    a_wb_value: assert property (@(posedge gwe) disable iff (!i_rst_n)
        retire |-> i_wb.rd_we == exp_rd_we[wb_idx] &&
                   (!i_wb.rd_we || (i_wb.rd == exp_rd[wb_idx] &&
                                    i_wb.rd_data == exp_data[wb_idx])))
    else begin
        $error("ERROR o_wb.rd_data pc %h got r%h=%h expected r%h=%h",
               $sampled(i_wb.pc), $sampled(i_wb.rd), $sampled(i_wb.rd_data),
               $sampled(exp_rd[wb_idx]), $sampled(exp_data[wb_idx]));
        error_count++;
    end

    a_wb_nzp: assert property (@(posedge gwe) disable iff (!i_rst_n)
        retire |-> i_wb.nzp_we == exp_rd_we[wb_idx] &&
                   (!i_wb.nzp_we || i_wb.nzp == sign_class(exp_data[wb_idx])))
    else begin
        $error("ERROR o_wb.nzp pc %h got %h expected %h",
               $sampled(i_wb.pc), $sampled(i_wb.nzp),
               sign_class($sampled(exp_data[wb_idx])));
        error_count++;
    end

    a_store: assert property (@(posedge gwe) disable iff (!i_rst_n)
        (i_dmem.we || (retire && exp_st[wb_idx])) |->
            (!i_dmem.we || (m_in_prog && exp_st[m_idx] &&
                            i_dmem.addr == exp_addr[m_idx] &&
                            i_dmem.wdata == exp_wdata[m_idx])) &&
            (!retire || i_wb.dmem_we == exp_st[wb_idx]))
    else begin
        $error("ERROR o_dmem pc %h got addr %h wdata %h expected addr %h wdata %h",
               $sampled(i_m_pc), $sampled(i_dmem.addr), $sampled(i_dmem.wdata),
               $sampled(exp_addr[m_idx]), $sampled(exp_wdata[m_idx]));
        error_count++;
    end

    a_store_trace: assert property (@(posedge gwe) disable iff (!i_rst_n)
        retire && exp_st[wb_idx] |-> i_wb.dmem_addr == exp_addr[wb_idx] &&
                                     i_wb.dmem_data == exp_wdata[wb_idx])
    else begin
        $error("ERROR o_wb.dmem_addr pc %h got addr %h data %h expected addr %h data %h",
               $sampled(i_wb.pc), $sampled(i_wb.dmem_addr), $sampled(i_wb.dmem_data),
               $sampled(exp_addr[wb_idx]), $sampled(exp_wdata[wb_idx]));
        error_count++;
    end

endmodule

bind lc4_pipeline lc4_pipeline_assertions checks_inst (
    .gwe     (gwe),
    .i_rst_n (i_rst_n),
    .i_wb    (o_wb),
    .i_dmem  (o_dmem),
    .i_m_pc  (m_q.pc)
);

`default_nettype wire

// ==== dv/tb_lc4_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_lc4_pipeline import lc4_pkg::*; ();

    localparam int    CLK_HALF       = 5;
    localparam int    RESET_CYCLES   = 5;
    localparam int    TIMEOUT_CYCLES = 200;
    localparam word_t LAST_PC        = RESET_PC + 16'd30;

    logic        gwe;
    logic        i_rst_n;
    word_t       imem_addr;
    insn_t       imem_insn;
    dmem_req_t   dmem_req;
    word_t       dmem_rdata;
    wb_trace_t   wb;
    word_t       imem_off;
    int unsigned cycles;

    insn_t imem [64];
    word_t dmem [256];

    lc4_pipeline lc4_pipeline_inst (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .o_imem_addr  (imem_addr),
        .i_imem_insn  (imem_insn),
        .o_dmem       (dmem_req),
        .i_dmem_rdata (dmem_rdata),
        .o_wb         (wb)
    );

    function automatic insn_t enc_rr(input logic [3:0] op, input logic [2:0] fn,
                                     input reg_idx_t rd, input reg_idx_t rs,
                                     input reg_idx_t rt);
        return {op, rd, rs, fn, rt};
    endfunction

    function automatic insn_t enc_addi(input reg_idx_t rd, input reg_idx_t rs,
                                       input logic [4:0] imm);
        return {OPC_ARITH, rd, rs, 1'b1, imm};
    endfunction

    function automatic insn_t enc_mem(input logic [3:0] op, input reg_idx_t r,
                                      input reg_idx_t rs, input logic [5:0] off);
        return {op, r, rs, off};
    endfunction

    function automatic insn_t enc_const(input reg_idx_t rd, input logic [8:0] imm);
        return {OPC_CONST, rd, imm};
    endfunction

    function automatic insn_t enc_br(input nzp_t cond, input logic [8:0] off);
        return {OPC_BR, cond, off};
    endfunction

    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
        end
        // every word differs so a wrong address shows up
        for (int i = 0; i < 256; i++) begin
            dmem[i] = (word_t'(i) * 16'h0101) ^ 16'h3c5a;
        end
        imem[0]  = enc_const(3'd1, 9'h005);
        imem[1]  = enc_const(3'd2, 9'h1fd);
        imem[2]  = enc_rr(OPC_ARITH, FN_ADD, 3'd3, 3'd1, 3'd2);
        imem[3]  = enc_rr(OPC_ARITH, FN_ADD, 3'd4, 3'd3, 3'd2);
        imem[4]  = enc_rr(OPC_LOGIC, FN_AND, 3'd5, 3'd4, 3'd1);
        imem[5]  = enc_rr(OPC_LOGIC, FN_OR, 3'd6, 3'd5, 3'd3);
        imem[6]  = enc_rr(OPC_LOGIC, FN_XOR, 3'd7, 3'd6, 3'd6);
        imem[7]  = enc_addi(3'd7, 3'd7, 5'h1f);
        imem[8]  = enc_const(3'd0, 9'h010);
        imem[9]  = enc_addi(3'd5, 3'd1, 5'h03);
        // store data straight from the previous instruction
        imem[10] = enc_mem(OPC_STR, 3'd5, 3'd0, 6'h02);
        imem[11] = enc_mem(OPC_LDR, 3'd2, 3'd0, 6'h02);
        imem[12] = enc_rr(OPC_ARITH, FN_ADD, 3'd3, 3'd2, 3'd1);
        imem[13] = enc_mem(OPC_STR, 3'd3, 3'd0, 6'h03);
        imem[14] = enc_mem(OPC_LDR, 3'd4, 3'd0, 6'h03);
        imem[15] = enc_mem(OPC_STR, 3'd4, 3'd0, 6'h04);
        imem[16] = enc_mem(OPC_LDR, 3'd5, 3'd0, 6'h04);
        imem[17] = enc_addi(3'd6, 3'd5, 5'h13);
        imem[18] = enc_br(3'b100, 9'h003);
        imem[19] = enc_br(3'b010, 9'h002);
        // flushed by the taken branch above
        imem[20] = enc_const(3'd1, 9'h055);
        imem[21] = enc_const(3'd1, 9'h066);
        imem[22] = enc_addi(3'd1, 3'd1, 5'h01);
        imem[23] = enc_br(3'b111, 9'h001);
        imem[24] = enc_const(3'd1, 9'h077);
        imem[25] = enc_rr(OPC_LOGIC, FN_XOR, 3'd2, 3'd1, 3'd5);
        imem[26] = enc_rr(OPC_ARITH, FN_SUB, 3'd3, 3'd2, 3'd7);
        imem[27] = '0;
        imem[28] = enc_mem(OPC_STR, 3'd3, 3'd0, 6'h05);
        imem[29] = enc_mem(OPC_LDR, 3'd4, 3'd0, 6'h05);
        imem[30] = enc_rr(OPC_ARITH, FN_ADD, 3'd6, 3'd4, 3'd4);
    endtask

    // both memories answer in the same cycle
    assign imem_off   = imem_addr - RESET_PC;
    assign imem_insn  = (imem_off < 16'd64) ? imem[imem_off[5:0]] : '0;
    assign dmem_rdata = dmem[dmem_req.addr[7:0]];

    always @(posedge gwe) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
        end
    end

    initial begin
        gwe = 1'b0;
    end

    always #CLK_HALF gwe = ~gwe;

    always @(posedge gwe) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Result: FAILED");
            $fatal(1, "timeout: the last program instruction never retired");
        end
    end

    always @(negedge gwe) begin
        if (lc4_pipeline_inst.checks_inst.error_count != 0) begin
            $display("Result: FAILED");
            $fatal(1, "a pipeline check failed");
        end
    end

    initial begin
        i_rst_n = 1'b0;
        cycles  = 0;
        load_program();
        repeat (RESET_CYCLES) @(negedge gwe);
        i_rst_n = 1'b1;
        do begin
            @(negedge gwe);
        end while (!(wb.stall == STALL_NONE && wb.pc == LAST_PC));
        // the checks on the last retire run at the rising edge in between
        @(negedge gwe);
        if (lc4_pipeline_inst.checks_inst.error_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $fatal(1, "pipeline checks reported errors");
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/lc4_pkg.sv
logic/lc4_decoder.sv
logic/lc4_alu.sv
logic/lc4_regfile.sv
logic/lc4_fetch_unit.sv
logic/lc4_hazard_unit.sv
logic/lc4_pipeline.sv
dv/lc4_pipeline_assertions.sv
dv/tb_lc4_pipeline.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the LC4 pipeline testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f \
    --top-module tb_lc4_pipeline -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
